//--- dtlb_defs.svh
// data TLB geometry and field widths
// ways, sets, page-word and address-space id widths
// plus the global flag position inside a page word
`ifndef DTLB_DEFS_SVH
`define DTLB_DEFS_SVH

// set-associative geometry
`define DTLB_WAYS 8
`define DTLB_WAY_W 3
`define DTLB_SETS 16
`define DTLB_SET_W 4

// request page number, lowest bit picks the odd page of a group
`define DTLB_VPN_W 21
`define DTLB_TAG_W 20

// page-table word and address-space id
`define DTLB_PTE_W 24
`define DTLB_ASID_W 8

// global flag inside every page word
`define DTLB_PTE_GLOBAL 0

// three consecutive page words per entry
`define DTLB_PTE_CNT 3

`endif

//--- dtlb_pkg.sv
// data TLB shared types
// request operation, reset sweep state and the stored entry
`default_nettype none

`include "dtlb_defs.svh"

package dtlb_pkg;

  // request operation
  typedef enum logic [1:0] {
    op_lookup = 2'd0,
    op_fill   = 2'd1,
    op_inval  = 2'd2
  } dtlb_op_e;

  // sweep clears every set once after reset
  typedef enum logic {
    st_sweep = 1'b0,
    st_run   = 1'b1
  } dtlb_init_e;

  // one stored translation
  // gbl is set only when all three words carry the global flag
  typedef struct packed {
    logic                                            valid;
    logic                                            gbl;
    logic [`DTLB_TAG_W-1:0]                          tag;
    logic [`DTLB_ASID_W-1:0]                         asid;
    logic [`DTLB_PTE_CNT-1:0][`DTLB_PTE_W-1:0]       pte;
  } dtlb_entry_t;

endpackage

`default_nettype wire

//--- dtlb_way_if.sv
// lookup and write fields shared by the decoder and all ways
// decode modport drives, way modport receives
`default_nettype none

`include "dtlb_defs.svh"

interface dtlb_way_if;

  // lookup side
  logic [`DTLB_TAG_W-1:0]                    look_tag;
  logic [`DTLB_ASID_W-1:0]                   look_asid;

  // write side
  logic                                      fill;
  logic                                      inval;
  logic [`DTLB_TAG_W-1:0]                    wr_tag;
  logic [`DTLB_ASID_W-1:0]                   wr_asid;
  logic [`DTLB_PTE_CNT-1:0][`DTLB_PTE_W-1:0] wr_pte;

  // reset sweep
  logic                                      sweep;
  logic [`DTLB_SET_W-1:0]                    sweep_idx;

  modport decode (
    output look_tag, look_asid, fill, inval, wr_tag, wr_asid, wr_pte, sweep, sweep_idx
  );

  modport way (
    input look_tag, look_asid, fill, inval, wr_tag, wr_asid, wr_pte, sweep, sweep_idx
  );

endinterface

`default_nettype wire

//--- dtlb_decode.sv
// request decode for the data TLB
// splits the page number, raises fill and invalidate strobes
// and runs the post-reset sweep over all sets
`default_nettype none

`include "dtlb_defs.svh"

module dtlb_decode (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         req_valid,
  input  wire dtlb_pkg::dtlb_op_e     req_op,
  input  wire [`DTLB_VPN_W-1:0]       req_vpn,
  input  wire [`DTLB_ASID_W-1:0]      req_asid,
  input  wire [`DTLB_PTE_W-1:0]       fill_data0,
  input  wire [`DTLB_PTE_W-1:0]       fill_data1,
  input  wire [`DTLB_PTE_W-1:0]       fill_data2,
  output logic                        ready,
  output logic                        wr_en,
  output logic [`DTLB_SET_W-1:0]      set_idx,
  output logic                        look_en,
  output logic                        odd_page,
  output logic                        sweep,
  dtlb_way_if.decode                  wbus
);
  import dtlb_pkg::*;

  localparam int last_set = `DTLB_SETS - 1;

  dtlb_init_e              state;
  logic [`DTLB_SET_W-1:0]  sweep_cnt;
  logic                    accept;
  logic [`DTLB_TAG_W-1:0]  group_tag;

  // requests outside the run state are dropped
  assign ready  = (state == st_run);
  assign sweep  = (state == st_sweep);
  assign accept = req_valid & ready;

  // page number = group tag plus odd-page bit, set index is the low tag bits
  assign group_tag = req_vpn[`DTLB_VPN_W-1:1];
  assign odd_page  = req_vpn[0];
  assign set_idx   = group_tag[`DTLB_SET_W-1:0];

  // every accepted request gets a response
  assign look_en = accept;
  assign wr_en   = accept & (req_op == op_fill);

  assign wbus.look_tag  = group_tag;
  assign wbus.look_asid = req_asid;
  assign wbus.fill      = wr_en;
  assign wbus.inval     = accept & (req_op == op_inval);
  assign wbus.wr_tag    = group_tag;
  assign wbus.wr_asid   = req_asid;
  assign wbus.wr_pte    = {fill_data2, fill_data1, fill_data0};
  assign wbus.sweep     = sweep;
  assign wbus.sweep_idx = sweep_cnt;

  // one set per cycle, ready follows the last one
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_sweep;
      sweep_cnt <= '0;
    end else if (state == st_sweep) begin
      sweep_cnt <= sweep_cnt + 1'b1;
      if (sweep_cnt == last_set[`DTLB_SET_W-1:0]) begin
        state <= st_run;
      end
    end
  end

endmodule

`default_nettype wire

//--- dtlb_way.sv
// one way of the data TLB
// 16-entry array, tag and address-space compare, write port
// covering sweep clear, fill and invalidate
`default_nettype none

`include "dtlb_defs.svh"

module dtlb_way #(
  parameter int way_no = 0
) (
  input  wire                    clk,
  dtlb_way_if.way                wbus,
  input  wire [`DTLB_WAYS-1:0]   wr_sel,
  output logic                   hit,
  output dtlb_pkg::dtlb_entry_t  entry
);
  import dtlb_pkg::*;

  dtlb_entry_t             mem [`DTLB_SETS];
  dtlb_entry_t             fill_entry;
  logic [`DTLB_SET_W-1:0]  rd_set;
  logic [`DTLB_SET_W-1:0]  wr_set;
  logic                    tag_match;
  logic                    asid_match;
  logic                    all_global;
  logic                    my_sel;

  assign rd_set = wbus.look_tag[`DTLB_SET_W-1:0];
  assign wr_set = wbus.sweep ? wbus.sweep_idx : wbus.wr_tag[`DTLB_SET_W-1:0];

  // asynchronous read of the addressed set
  assign entry = mem[rd_set];

  assign tag_match  = (entry.tag == wbus.look_tag);
  // global entries match any address space
  assign asid_match = (entry.asid == wbus.look_asid) | entry.gbl;
  assign hit        = entry.valid & tag_match & asid_match;

  // the replacement unit points at exactly one way for a fill
  assign my_sel = wr_sel[way_no];

  // global only when every word of the group says so
  assign all_global = wbus.wr_pte[0][`DTLB_PTE_GLOBAL] &
                      wbus.wr_pte[1][`DTLB_PTE_GLOBAL] &
                      wbus.wr_pte[2][`DTLB_PTE_GLOBAL];

  always_comb begin
    fill_entry       = '0;
    fill_entry.valid = 1'b1;
    fill_entry.gbl   = all_global;
    fill_entry.tag   = wbus.wr_tag;
    fill_entry.asid  = wbus.wr_asid;
    fill_entry.pte   = wbus.wr_pte;
  end

  // writes land at the sampling edge, a following lookup sees them
  always_ff @(posedge clk) begin
    if (wbus.sweep) begin
      mem[wr_set] <= '0;
    end else if (wbus.fill && my_sel) begin
      mem[wr_set] <= fill_entry;
    end else if (wbus.inval && hit) begin
      // lookup and write share the set index, so hit refers to wr_set
      mem[wr_set].valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- dtlb_replace.sv
// replacement state of the data TLB
// per-set age array, victim choice and fill way selection
`default_nettype none

`include "dtlb_defs.svh"

module dtlb_replace (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         sweep,
  input  wire [`DTLB_SET_W-1:0]       sweep_idx,
  input  wire [`DTLB_SET_W-1:0]       set_idx,
  input  wire                         look_en,
  input  wire                         wr_en,
  input  wire [`DTLB_WAYS-1:0]        hit_vec,
  input  wire                         force_way_en,
  input  wire [`DTLB_WAY_W-1:0]       force_way,
  output logic [`DTLB_WAYS-1:0]       wr_sel
);

  localparam logic [`DTLB_WAYS-1:0] way0_hot = 1;

  // age 0 is most recent, oldest way has age ways-1
  logic [`DTLB_WAY_W-1:0] age [`DTLB_SETS][`DTLB_WAYS];
  logic [`DTLB_WAY_W-1:0] victim;
  logic [`DTLB_WAY_W-1:0] touched_age;
  logic [`DTLB_WAYS-1:0]  touched;
  logic                   hit_any;
  logic                   age_upd;

  assign hit_any = |hit_vec;

  // ages of a set are always a permutation, so one way is the oldest
  always_comb begin
    victim = '0;
    for (int w = 0; w < `DTLB_WAYS; w++) begin
      if (age[set_idx][w] == '1) begin
        victim = w[`DTLB_WAY_W-1:0];
      end
    end
  end

  // existing tag first, then forced way, then oldest
  always_comb begin
    if (hit_any) begin
      wr_sel = hit_vec;
    end else if (force_way_en) begin
      wr_sel = way0_hot << force_way;
    end else begin
      wr_sel = way0_hot << victim;
    end
  end

  assign touched = wr_en ? wr_sel : hit_vec;
  assign age_upd = wr_en | (look_en & hit_any);

  always_comb begin
    touched_age = '0;
    for (int w = 0; w < `DTLB_WAYS; w++) begin
      if (touched[w]) begin
        touched_age = age[set_idx][w];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      if (sweep) begin
        for (int w = 0; w < `DTLB_WAYS; w++) begin
          age[sweep_idx][w] <= w[`DTLB_WAY_W-1:0];
        end
      end else if (age_upd) begin
        for (int w = 0; w < `DTLB_WAYS; w++) begin
          if (touched[w]) begin
            age[set_idx][w] <= '0;
          end else if (age[set_idx][w] < touched_age) begin
            age[set_idx][w] <= age[set_idx][w] + 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- dtlb_result.sv
// response stage of the data TLB
// merges the hitting way, encodes its number, picks the page pair
// and registers the response
`default_nettype none

`include "dtlb_defs.svh"

module dtlb_result (
  input  wire                                         clk,
  input  wire                                         rst,
  input  wire                                         look_en,
  input  wire                                         odd_page,
  input  wire [`DTLB_WAYS-1:0]                        hit_vec,
  input  wire dtlb_pkg::dtlb_entry_t [`DTLB_WAYS-1:0] entries,
  output logic                                        rsp_valid,
  output logic                                        rsp_hit,
  output logic [`DTLB_WAY_W-1:0]                      rsp_way,
  output logic [`DTLB_PTE_W-1:0]                      rsp_data,
  output logic [`DTLB_PTE_W-1:0]                      rsp_data_next
);
  import dtlb_pkg::*;

  dtlb_entry_t             merged;
  logic [`DTLB_WAY_W-1:0]  way_enc;
  logic                    hit_any;

  assign hit_any = |hit_vec;

  // at most one way hits, so an OR merge is enough
  // and a miss leaves everything at zero
  always_comb begin
    merged  = '0;
    way_enc = '0;
    for (int w = 0; w < `DTLB_WAYS; w++) begin
      if (hit_vec[w]) begin
        merged  = merged | entries[w];
        way_enc = way_enc | w[`DTLB_WAY_W-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid <= 1'b0;
      rsp_hit   <= 1'b0;
    end else begin
      rsp_valid <= look_en;
      rsp_hit   <= look_en & hit_any;
    end
  end

  // even page returns words 0 and 1, odd page words 1 and 2
  always_ff @(posedge clk) begin
    if (look_en) begin
      rsp_way       <= way_enc;
      rsp_data      <= odd_page ? merged.pte[1] : merged.pte[0];
      rsp_data_next <= odd_page ? merged.pte[2] : merged.pte[1];
    end
  end

endmodule

`default_nettype wire

//--- dtlb_top.sv
// data TLB top level
// decoder, eight ways, replacement and response stage
`default_nettype none

`include "dtlb_defs.svh"

module dtlb_top (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       req_valid,
  input  wire dtlb_pkg::dtlb_op_e   req_op,
  input  wire [`DTLB_VPN_W-1:0]     req_vpn,
  input  wire [`DTLB_ASID_W-1:0]    req_asid,
  input  wire [`DTLB_PTE_W-1:0]     fill_data0,
  input  wire [`DTLB_PTE_W-1:0]     fill_data1,
  input  wire [`DTLB_PTE_W-1:0]     fill_data2,
  input  wire                       force_way_en,
  input  wire [`DTLB_WAY_W-1:0]     force_way,
  output wire                       ready,
  output wire                       rsp_valid,
  output wire                       rsp_hit,
  output wire [`DTLB_WAY_W-1:0]     rsp_way,
  output wire [`DTLB_PTE_W-1:0]     rsp_data,
  output wire [`DTLB_PTE_W-1:0]     rsp_data_next
);
  import dtlb_pkg::*;

  dtlb_way_if wbus ();

  wire                                wr_en;
  wire [`DTLB_SET_W-1:0]              set_idx;
  wire                                look_en;
  wire                                odd_page;
  wire                                sweep;
  wire [`DTLB_WAYS-1:0]               hit_vec;
  wire [`DTLB_WAYS-1:0]               wr_sel;
  dtlb_entry_t [`DTLB_WAYS-1:0]       entries;

  dtlb_decode u_decode (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_op     (req_op),
    .req_vpn    (req_vpn),
    .req_asid   (req_asid),
    .fill_data0 (fill_data0),
    .fill_data1 (fill_data1),
    .fill_data2 (fill_data2),
    .ready      (ready),
    .wr_en      (wr_en),
    .set_idx    (set_idx),
    .look_en    (look_en),
    .odd_page   (odd_page),
    .sweep      (sweep),
    .wbus       (wbus)
  );

  for (genvar k = 0; k < `DTLB_WAYS; k++) begin : g_way
    dtlb_way #(.way_no(k)) u_way (
      .clk    (clk),
      .wbus   (wbus),
      .wr_sel (wr_sel),
      .hit    (hit_vec[k]),
      .entry  (entries[k])
    );
  end

  // invalidates leave the ages alone
  dtlb_replace u_replace (
    .clk          (clk),
    .rst          (rst),
    .sweep        (sweep),
    .sweep_idx    (wbus.sweep_idx),
    .set_idx      (set_idx),
    .look_en      (look_en & ~wbus.inval),
    .wr_en        (wr_en),
    .hit_vec      (hit_vec),
    .force_way_en (force_way_en),
    .force_way    (force_way),
    .wr_sel       (wr_sel)
  );

  dtlb_result u_result (
    .clk           (clk),
    .rst           (rst),
    .look_en       (look_en),
    .odd_page      (odd_page),
    .hit_vec       (hit_vec),
    .entries       (entries),
    .rsp_valid     (rsp_valid),
    .rsp_hit       (rsp_hit),
    .rsp_way       (rsp_way),
    .rsp_data      (rsp_data),
    .rsp_data_next (rsp_data_next)
  );

endmodule

`default_nettype wire

//--- dtlb_checker.sv
// testbench checker for the data TLB
// watches the DUT ports, keeps a model of entries and ages
// and compares every response against it
`default_nettype none

`include "dtlb_defs.svh"

module dtlb_checker (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     ready,
  input  wire                     req_valid,
  input  wire dtlb_pkg::dtlb_op_e req_op,
  input  wire [`DTLB_VPN_W-1:0]   req_vpn,
  input  wire [`DTLB_ASID_W-1:0]  req_asid,
  input  wire [`DTLB_PTE_W-1:0]   fill_data0,
  input  wire [`DTLB_PTE_W-1:0]   fill_data1,
  input  wire [`DTLB_PTE_W-1:0]   fill_data2,
  input  wire                     force_way_en,
  input  wire [`DTLB_WAY_W-1:0]   force_way,
  input  wire                     rsp_valid,
  input  wire                     rsp_hit,
  input  wire [`DTLB_WAY_W-1:0]   rsp_way,
  input  wire [`DTLB_PTE_W-1:0]   rsp_data,
  input  wire [`DTLB_PTE_W-1:0]   rsp_data_next,
  output logic                    busy,
  output int                      checks,
  output int                      errors
);
  import dtlb_pkg::*;

  // model state, indexed by set and way
  logic                     m_valid [`DTLB_SETS][`DTLB_WAYS];
  logic                     m_gbl   [`DTLB_SETS][`DTLB_WAYS];
  logic [`DTLB_TAG_W-1:0]   m_tag   [`DTLB_SETS][`DTLB_WAYS];
  logic [`DTLB_ASID_W-1:0]  m_asid  [`DTLB_SETS][`DTLB_WAYS];
  logic [`DTLB_PTE_W-1:0]   m_pte   [`DTLB_SETS][`DTLB_WAYS][`DTLB_PTE_CNT];
  logic [`DTLB_WAY_W-1:0]   m_age   [`DTLB_SETS][`DTLB_WAYS];
  int                       cyc;
  logic                     exp_hit;
  logic [`DTLB_WAY_W-1:0]   exp_way;
  logic [`DTLB_PTE_W-1:0]   exp_data;
  logic [`DTLB_PTE_W-1:0]   exp_next;

  initial begin
    checks = 0;
    errors = 0;
    busy   = 1'b0;
  end

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at time %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  // touched way becomes age 0, ways younger than its old age move up one
  task automatic touch(input int s, input int w);
    logic [`DTLB_WAY_W-1:0] old;
    old = m_age[s][w];
    for (int v = 0; v < `DTLB_WAYS; v++) begin
      if (v == w) begin
        m_age[s][v] = '0;
      end else if (m_age[s][v] < old) begin
        m_age[s][v] = m_age[s][v] + 1'b1;
      end
    end
  endtask

  always @(posedge clk) begin : watch
    logic [`DTLB_TAG_W-1:0] tag;
    int                     s;
    int                     odd;
    int                     hw;
    int                     tgt;
    if (rst) begin
      cyc  = 0;
      busy = 1'b0;
      for (int i = 0; i < `DTLB_SETS; i++) begin
        for (int w = 0; w < `DTLB_WAYS; w++) begin
          m_valid[i][w] = 1'b0;
          m_age[i][w]   = w[`DTLB_WAY_W-1:0];
        end
      end
    end else begin
      // ready stays low for one sweep of all sets
      compare("ready", ready, cyc >= `DTLB_SETS);
      compare("rsp_valid", rsp_valid, busy);
      if (busy) begin
        compare("rsp_hit", rsp_hit, exp_hit);
        compare("rsp_way", rsp_way, exp_way);
        compare("rsp_data", rsp_data, exp_data);
        compare("rsp_data_next", rsp_data_next, exp_next);
      end
      busy = 1'b0;
      if (req_valid && cyc >= `DTLB_SETS) begin
        tag = req_vpn[`DTLB_VPN_W-1:1];
        s   = tag[`DTLB_SET_W-1:0];
        odd = req_vpn[0];
        hw  = -1;
        for (int w = 0; w < `DTLB_WAYS; w++) begin
          if (m_valid[s][w] && m_tag[s][w] == tag &&
              (m_asid[s][w] == req_asid || m_gbl[s][w])) begin
            hw = w;
          end
        end
        // response shows the state before any write
        busy     = 1'b1;
        exp_hit  = (hw >= 0);
        exp_way  = '0;
        exp_data = '0;
        exp_next = '0;
        if (exp_hit) begin
          exp_way  = hw[`DTLB_WAY_W-1:0];
          exp_data = m_pte[s][hw][odd];
          exp_next = m_pte[s][hw][odd + 1];
        end
        case (req_op)
          op_lookup: begin
            if (exp_hit) begin
              touch(s, hw);
            end
          end
          op_fill: begin
            tgt = hw;
            if (!exp_hit) begin
              for (int w = 0; w < `DTLB_WAYS; w++) begin
                if (m_age[s][w] == 3'd7) begin
                  tgt = w;
                end
              end
              if (force_way_en) begin
                tgt = force_way;
              end
            end
            m_valid[s][tgt]  = 1'b1;
            m_gbl[s][tgt]    = fill_data0[`DTLB_PTE_GLOBAL] & fill_data1[`DTLB_PTE_GLOBAL] &
                               fill_data2[`DTLB_PTE_GLOBAL];
            m_tag[s][tgt]    = tag;
            m_asid[s][tgt]   = req_asid;
            m_pte[s][tgt][0] = fill_data0;
            m_pte[s][tgt][1] = fill_data1;
            m_pte[s][tgt][2] = fill_data2;
            touch(s, tgt);
          end
          op_inval: begin
            if (exp_hit) begin
              m_valid[s][hw] = 1'b0;
            end
          end
          default: begin
          end
        endcase
      end
      if (cyc < `DTLB_SETS) begin
        cyc++;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_dtlb.sv
// testbench top for the data TLB
// clock and reset, directed and seeded random requests,
// checker hookup and the closing report
`default_nettype none

`include "dtlb_defs.svh"

module tb_dtlb;
  import dtlb_pkg::*;

  logic                     clk;
  logic                     rst;
  logic                     req_valid;
  dtlb_op_e                 req_op;
  logic [`DTLB_VPN_W-1:0]   req_vpn;
  logic [`DTLB_ASID_W-1:0]  req_asid;
  logic [`DTLB_PTE_W-1:0]   fill_data0;
  logic [`DTLB_PTE_W-1:0]   fill_data1;
  logic [`DTLB_PTE_W-1:0]   fill_data2;
  logic                     force_way_en;
  logic [`DTLB_WAY_W-1:0]   force_way;
  wire                      ready;
  wire                      rsp_valid;
  wire                      rsp_hit;
  wire  [`DTLB_WAY_W-1:0]   rsp_way;
  wire  [`DTLB_PTE_W-1:0]   rsp_data;
  wire  [`DTLB_PTE_W-1:0]   rsp_data_next;
  logic                     busy;
  int                       checks;
  int                       errors;
  int                       timeouts;
  integer                   seed;

  dtlb_top uut (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (req_valid),
    .req_op        (req_op),
    .req_vpn       (req_vpn),
    .req_asid      (req_asid),
    .fill_data0    (fill_data0),
    .fill_data1    (fill_data1),
    .fill_data2    (fill_data2),
    .force_way_en  (force_way_en),
    .force_way     (force_way),
    .ready         (ready),
    .rsp_valid     (rsp_valid),
    .rsp_hit       (rsp_hit),
    .rsp_way       (rsp_way),
    .rsp_data      (rsp_data),
    .rsp_data_next (rsp_data_next)
  );

  dtlb_checker chk (
    .clk           (clk),
    .rst           (rst),
    .ready         (ready),
    .req_valid     (req_valid),
    .req_op        (req_op),
    .req_vpn       (req_vpn),
    .req_asid      (req_asid),
    .fill_data0    (fill_data0),
    .fill_data1    (fill_data1),
    .fill_data2    (fill_data2),
    .force_way_en  (force_way_en),
    .force_way     (force_way),
    .rsp_valid     (rsp_valid),
    .rsp_hit       (rsp_hit),
    .rsp_way       (rsp_way),
    .rsp_data      (rsp_data),
    .rsp_data_next (rsp_data_next),
    .busy          (busy),
    .checks        (checks),
    .errors        (errors)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // presents one request from this falling edge to the next
  task automatic send(input logic valid, input dtlb_op_e op,
                      input logic [`DTLB_VPN_W-1:0] vpn, input logic [`DTLB_ASID_W-1:0] asid,
                      input logic fen, input logic [`DTLB_WAY_W-1:0] fway);
    logic glb;
    @(negedge clk);
    // about one fill in four is global in all three words
    glb          = ($random(seed) & 3) == 0;
    req_valid    = valid;
    req_op       = op;
    req_vpn      = vpn;
    req_asid     = asid;
    force_way_en = fen;
    force_way    = fway;
    fill_data0   = $random(seed);
    fill_data1   = $random(seed);
    fill_data2   = $random(seed);
    if (glb) begin
      fill_data0[`DTLB_PTE_GLOBAL] = 1'b1;
      fill_data1[`DTLB_PTE_GLOBAL] = 1'b1;
      fill_data2[`DTLB_PTE_GLOBAL] = 1'b1;
    end
  endtask

  // twelve tags in each of sets 3 and 9, more than the ways of a set
  function automatic logic [`DTLB_VPN_W-1:0] pool_vpn(input int pick, input logic hi_set,
                                                       input logic odd);
    logic [`DTLB_TAG_W-1:0] tag;
    tag = `DTLB_TAG_W'(pick * 16 + (hi_set ? 9 : 3));
    return {tag, odd};
  endfunction

  initial begin : stim
    int                      pick;
    int                      k;
    int                      t;
    dtlb_op_e                op;
    logic [`DTLB_ASID_W-1:0] asid;
    seed         = 32'h2e01_d00f;
    timeouts     = 0;
    rst          = 1'b1;
    req_valid    = 1'b0;
    req_op       = op_lookup;
    req_vpn      = '0;
    req_asid     = '0;
    fill_data0   = '0;
    fill_data1   = '0;
    fill_data2   = '0;
    force_way_en = 1'b0;
    force_way    = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // fills offered during the sweep are dropped
    t = 0;
    while (!ready && t < 40) begin
      send(1'b1, op_fill, pool_vpn(t % 12, 1'b0, 1'b0), 8'(t % 2), 1'b0, 3'd0);
      t++;
    end
    if (!ready) begin
      timeouts++;
      $display("timeout: ready stayed low after reset");
    end else begin
      // tags that were never filled, one per set
      for (int s = 0; s < `DTLB_SETS; s++) begin
        send(1'b1, op_lookup, {16'hffff, 4'(s), 1'b0}, 8'd0, 1'b0, 3'd0);
      end
      // nine tags into set 5 force one eviction
      for (int i = 0; i < 9; i++) begin
        send(1'b1, op_fill, {`DTLB_TAG_W'(i * 16 + 5), 1'b0}, 8'(i % 2), 1'b0, 3'd0);
      end
      for (int i = 0; i < 9; i++) begin
        send(1'b1, op_lookup, {`DTLB_TAG_W'(i * 16 + 5), 1'b1}, 8'(i % 2), 1'b0, 3'd0);
      end
      for (int n = 0; n < 1500; n++) begin
        pick = $unsigned($random(seed)) % 12;
        k    = $unsigned($random(seed)) % 20;
        asid = 8'($random(seed) & 1);
        if (k < 9) begin
          op = op_lookup;
        end else if (k < 16) begin
          op = op_fill;
        end else begin
          op = op_inval;
        end
        // fills keep one asid per tag, so a tag never sits in two ways
        if (op == op_fill) begin
          asid = 8'(pick % 2);
        end
        send(($random(seed) & 7) != 0, op, pool_vpn(pick, $random(seed) & 1, $random(seed) & 1),
             asid, ($random(seed) & 3) == 0, 3'($random(seed)));
      end
      send(1'b0, op_lookup, '0, '0, 1'b0, 3'd0);
      t = 0;
      while (busy && t < 20) begin
        @(negedge clk);
        t++;
      end
      if (busy) begin
        timeouts++;
        $display("timeout: last response never arrived");
      end
    end

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+.
dtlb_pkg.sv
dtlb_way_if.sv
dtlb_decode.sv
dtlb_way.sv
dtlb_replace.sv
dtlb_result.sv
dtlb_top.sv
dtlb_checker.sv
tb_dtlb.sv
